/* verilog/usb_rf_pkg.sv */
//////////////////////////////////////////////////
// Register map, field positions, width types and
// packed structs of the USB function registers
//////////////////////////////////////////////////
package usb_rf_pkg;

    //////////////////////////////////////////////////
    // Width types

    typedef logic [6:0]  reg_adr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [6:0]  funct_adr_t;
    typedef logic [8:0]  int_msk_t;
    typedef logic [7:0]  vend_stat_t;
    typedef logic [3:0]  vend_ctrl_t;

    //////////////////////////////////////////////////
    // Line state and event groups

    // Same layout as bits 4..0 of the main status word
    typedef struct packed {
        logic [1:0] line_stat;
        logic       usb_attached;
        logic       mode_hs;
        logic       suspend;
    } usb_line_status_t;

    // Raw strobes from the packet decoder
    typedef struct packed {
        logic usb_reset;
        logic rx_err;
        logic nse_err;
        logic pid_cs_err;
        logic crc5_err;
    } usb_err_t;

    // One-cycle pulses, interrupt source bits 8 down to 0
    typedef struct packed {
        logic usb_reset;
        logic rx_err;
        logic deattach;
        logic attach;
        logic suspend_end;
        logic suspend_start;
        logic nse_err;
        logic pid_cs_err;
        logic crc5_err;
    } usb_event_t;

    // Sticky copy of the event pulses
    typedef struct packed {
        logic usb_reset;
        logic rx_err;
        logic deattach;
        logic attach;
        logic suspend_end;
        logic suspend_start;
        logic nse_err;
        logic pid_cs_err;
        logic crc5_err;
    } int_src_t;

    //////////////////////////////////////////////////
    // Register indices

    localparam reg_adr_t REG_MAIN_CSR  = 7'd0;
    localparam reg_adr_t REG_FUNCT_ADR = 7'd1;
    localparam reg_adr_t REG_INT_MSK   = 7'd2;
    localparam reg_adr_t REG_INT_SRC   = 7'd3;
    localparam reg_adr_t REG_FRAME     = 7'd4;
    localparam reg_adr_t REG_VEND      = 7'd5;

    // Field positions inside the data word
    localparam int RESUME_BIT   = 5;
    localparam int INTA_MSK_LSB = 0;
    localparam int INTB_MSK_LSB = 16;
    localparam int INT_SRC_LSB  = 16;

endpackage

/* verilog/usb_line_events.sv */
//////////////////////////////////////////////////
// Line event detector for error strobes and
// attach and suspend level changes
//////////////////////////////////////////////////
`timescale 1ns/1ps

module usb_line_events (
    input  logic                         wclk,
    input  logic                         rst,
    input  usb_rf_pkg::usb_line_status_t line_status,
    input  usb_rf_pkg::usb_err_t         errs,
    output usb_rf_pkg::usb_event_t       events
);

    usb_rf_pkg::usb_err_t errs_r;
    logic                 attach_r;
    logic                 attach_r1;
    logic                 suspend_r;
    logic                 suspend_r1;

    //////////////////////////////////////////////////
    // Sampling

    // Error strobes, one stage
    always_ff @(posedge wclk)
    begin
        if (!rst)
            errs_r <= '0;
        else
            errs_r <= errs;
    end

    // Attach and suspend levels, two stages for edge detection
    always_ff @(posedge wclk)
    begin
        attach_r   <= line_status.usb_attached;
        attach_r1  <= attach_r;
        suspend_r  <= line_status.suspend;
        suspend_r1 <= suspend_r;
    end

    //////////////////////////////////////////////////
    // Event pulses

    always_comb
    begin
        events.usb_reset     = errs_r.usb_reset;
        events.rx_err        = errs_r.rx_err;
        events.deattach      = attach_r1 & ~attach_r;
        events.attach        = ~attach_r1 & attach_r;
        events.suspend_end   = suspend_r1 & ~suspend_r;
        events.suspend_start = ~suspend_r1 & suspend_r;
        events.nse_err       = errs_r.nse_err;
        events.pid_cs_err    = errs_r.pid_cs_err;
        events.crc5_err      = errs_r.crc5_err;
    end

    // Opposite edges of one level never pulse together
    attach_excl_a: assert property (@(posedge wclk) disable iff (!rst)
        !(events.attach && events.deattach));

    suspend_excl_a: assert property (@(posedge wclk) disable iff (!rst)
        !(events.suspend_start && events.suspend_end));

endmodule

/* verilog/usb_int_source.sv */
//////////////////////////////////////////////////
// Sticky interrupt source bits
//////////////////////////////////////////////////
`timescale 1ns/1ps

module usb_int_source (
    input  logic                   wclk,
    input  logic                   rst,
    input  usb_rf_pkg::usb_event_t events,
    input  logic                   int_src_clr,
    output usb_rf_pkg::int_src_t   int_src
);

    usb_rf_pkg::int_src_t int_src_nxt;

    // Accumulate new pulses onto the held bits
    always_comb
    begin
        int_src_nxt = usb_rf_pkg::int_src_t'(int_src | events);
    end

    // Clear on read wins over a set in the same cycle
    always_ff @(posedge wclk)
    begin
        if (!rst)
            int_src <= '0;
        else if (int_src_clr)
            int_src <= '0;
        else
            int_src <= int_src_nxt;
    end

    // A read of the source register empties it on the next edge
    clr_empties_a: assert property (@(posedge wclk) disable iff (!rst)
        int_src_clr |=> (int_src == '0));

endmodule

/* verilog/usb_func_regs.sv */
//////////////////////////////////////////////////
// Function register block with decode, writable
// registers, vendor control, resume and read data
//////////////////////////////////////////////////
`timescale 1ns/1ps

module usb_func_regs (
    input  logic                         wclk,
    input  logic                         rst,
    input  usb_rf_pkg::reg_adr_t         adr,
    input  logic                         re,
    input  logic                         we,
    input  usb_rf_pkg::reg_data_t        din,
    output usb_rf_pkg::reg_data_t        dout,
    input  usb_rf_pkg::usb_line_status_t line_status,
    input  usb_rf_pkg::int_src_t         int_src,
    output logic                         int_src_clr,
    input  usb_rf_pkg::reg_data_t        frm_nat,
    input  usb_rf_pkg::vend_stat_t       utmi_vend_stat,
    output usb_rf_pkg::vend_ctrl_t       utmi_vend_ctrl,
    output logic                         utmi_vend_wr,
    output logic                         rf_resume_req
);

    logic hit_main;
    logic hit_funct;
    logic hit_msk;
    logic hit_src;
    logic hit_vend;
    logic vend_wr_set;
    logic resume_set;

    usb_rf_pkg::funct_adr_t funct_adr;
    usb_rf_pkg::int_msk_t   inta_msk;
    usb_rf_pkg::int_msk_t   intb_msk;
    usb_rf_pkg::vend_stat_t vend_stat_r;
    usb_rf_pkg::reg_data_t  rd_word;

    //////////////////////////////////////////////////
    // Address decode

    assign hit_main  = (adr == usb_rf_pkg::REG_MAIN_CSR);
    assign hit_funct = (adr == usb_rf_pkg::REG_FUNCT_ADR);
    assign hit_msk   = (adr == usb_rf_pkg::REG_INT_MSK);
    assign hit_src   = (adr == usb_rf_pkg::REG_INT_SRC);
    assign hit_vend  = (adr == usb_rf_pkg::REG_VEND);

    // Every write cycle acts on its own
    assign vend_wr_set = we & hit_vend;
    assign resume_set  = we & hit_main & din[usb_rf_pkg::RESUME_BIT];

    //////////////////////////////////////////////////
    // Writable registers

    always_ff @(posedge wclk)
    begin
        if (!rst)
            funct_adr <= '0;
        else if (we && hit_funct)
            funct_adr <= din[$bits(usb_rf_pkg::funct_adr_t)-1:0];
    end

    // Two mask fields share one word
    always_ff @(posedge wclk)
    begin
        if (!rst)
        begin
            inta_msk <= '0;
            intb_msk <= '0;
        end
        else if (we && hit_msk)
        begin
            inta_msk <= din[usb_rf_pkg::INTA_MSK_LSB +: $bits(usb_rf_pkg::int_msk_t)];
            intb_msk <= din[usb_rf_pkg::INTB_MSK_LSB +: $bits(usb_rf_pkg::int_msk_t)];
        end
    end

    // UTMI vendor bus
    always_ff @(posedge wclk)
    begin
        vend_stat_r <= utmi_vend_stat;
        if (vend_wr_set)
            utmi_vend_ctrl <= din[$bits(usb_rf_pkg::vend_ctrl_t)-1:0];
    end

    //////////////////////////////////////////////////
    // Strobes

    always_ff @(posedge wclk)
    begin
        if (!rst)
        begin
            utmi_vend_wr  <= 1'b0;
            rf_resume_req <= 1'b0;
            int_src_clr   <= 1'b0;
        end
        else
        begin
            utmi_vend_wr  <= vend_wr_set;
            rf_resume_req <= resume_set;
            // Reading the source register drains it
            int_src_clr   <= re & hit_src;
        end
    end

    //////////////////////////////////////////////////
    // Read data

    always_comb
    begin
        rd_word = '0;
        case (adr)
            usb_rf_pkg::REG_MAIN_CSR:
                rd_word[$bits(usb_rf_pkg::usb_line_status_t)-1:0] = line_status;
            usb_rf_pkg::REG_FUNCT_ADR:
                rd_word[$bits(usb_rf_pkg::funct_adr_t)-1:0] = funct_adr;
            usb_rf_pkg::REG_INT_MSK:
            begin
                rd_word[usb_rf_pkg::INTA_MSK_LSB +: $bits(usb_rf_pkg::int_msk_t)] = inta_msk;
                rd_word[usb_rf_pkg::INTB_MSK_LSB +: $bits(usb_rf_pkg::int_msk_t)] = intb_msk;
            end
            usb_rf_pkg::REG_INT_SRC:
                rd_word[usb_rf_pkg::INT_SRC_LSB +: $bits(usb_rf_pkg::int_src_t)] = int_src;
            usb_rf_pkg::REG_FRAME:
                rd_word = frm_nat;
            usb_rf_pkg::REG_VEND:
                rd_word[$bits(usb_rf_pkg::vend_stat_t)-1:0] = vend_stat_r;
            default:
                rd_word = '0;
        endcase
    end

    // Registered every cycle whether or not re is high
    always_ff @(posedge wclk)
    begin
        dout <= rd_word;
    end

    // Pulses toward the PHY last a single cycle
    vend_wr_pulse_a: assert property (@(posedge wclk) disable iff (!rst)
        utmi_vend_wr |=> !utmi_vend_wr);

    resume_pulse_a: assert property (@(posedge wclk) disable iff (!rst)
        rf_resume_req |=> !rf_resume_req);

endmodule

/* verilog/usb_rf_top.sv */
//////////////////////////////////////////////////
// Top level of the USB function register block
//////////////////////////////////////////////////
`timescale 1ns/1ps

module usb_rf_top (
    input  logic                         wclk,
    input  logic                         rst,

    // Host bus
    input  usb_rf_pkg::reg_adr_t         adr,
    input  logic                         re,
    input  logic                         we,
    input  usb_rf_pkg::reg_data_t        din,
    output usb_rf_pkg::reg_data_t        dout,

    // PHY side
    input  usb_rf_pkg::usb_line_status_t line_status,
    input  usb_rf_pkg::usb_err_t         errs,
    input  usb_rf_pkg::reg_data_t        frm_nat,
    input  usb_rf_pkg::vend_stat_t       utmi_vend_stat,
    output usb_rf_pkg::vend_ctrl_t       utmi_vend_ctrl,
    output logic                         utmi_vend_wr,
    output logic                         rf_resume_req
);

    usb_rf_pkg::usb_event_t events;
    usb_rf_pkg::int_src_t   int_src;
    logic                   int_src_clr;

    // Event producer
    usb_line_events events0 (
        .wclk        (wclk),
        .rst         (rst),
        .line_status (line_status),
        .errs        (errs),
        .events      (events)
    );

    // Sticky source bits
    usb_int_source int_src0 (
        .wclk        (wclk),
        .rst         (rst),
        .events      (events),
        .int_src_clr (int_src_clr),
        .int_src     (int_src)
    );

    // Bus registers, drain the source bits on read
    usb_func_regs regs0 (
        .wclk           (wclk),
        .rst            (rst),
        .adr            (adr),
        .re             (re),
        .we             (we),
        .din            (din),
        .dout           (dout),
        .line_status    (line_status),
        .int_src        (int_src),
        .int_src_clr    (int_src_clr),
        .frm_nat        (frm_nat),
        .utmi_vend_stat (utmi_vend_stat),
        .utmi_vend_ctrl (utmi_vend_ctrl),
        .utmi_vend_wr   (utmi_vend_wr),
        .rf_resume_req  (rf_resume_req)
    );

endmodule

/* test/usb_rf_tb.sv */
//////////////////////////////////////////////////
// Testbench with clock, stimulus, reference model
// and assertion checks for the register block
//////////////////////////////////////////////////
`timescale 1ns/1ps

module usb_rf_tb;

    localparam int          CLK_HALF  = 4;
    localparam logic [31:0] SEED      = 32'hc878;
    localparam int          PULSE_MAX = 8;

    logic                         wclk;
    logic                         rst;
    usb_rf_pkg::reg_adr_t         adr;
    logic                         re;
    logic                         we;
    usb_rf_pkg::reg_data_t        din;
    usb_rf_pkg::reg_data_t        dout;
    usb_rf_pkg::usb_line_status_t line_status;
    usb_rf_pkg::usb_err_t         errs;
    usb_rf_pkg::reg_data_t        frm_nat;
    usb_rf_pkg::vend_stat_t       utmi_vend_stat;
    usb_rf_pkg::vend_ctrl_t       utmi_vend_ctrl;
    logic                         utmi_vend_wr;
    logic                         rf_resume_req;

    logic chk_on;
    logic noise_on;
    int   err_cnt;

    //////////////////////////////////////////////////
    // Reference model state

    usb_rf_pkg::funct_adr_t m_funct;
    usb_rf_pkg::int_msk_t   m_inta;
    usb_rf_pkg::int_msk_t   m_intb;
    usb_rf_pkg::int_src_t   m_src;
    usb_rf_pkg::usb_event_t m_ev;
    usb_rf_pkg::usb_err_t   m_errs_r;
    usb_rf_pkg::vend_stat_t m_vstat_r;
    usb_rf_pkg::vend_ctrl_t m_vctrl;
    usb_rf_pkg::reg_data_t  exp_dout;
    logic                   m_vctrl_ok;
    logic                   m_clr;
    logic                   m_vend_wr;
    logic                   m_resume;
    logic                   m_att0;
    logic                   m_att1;
    logic                   m_sus0;
    logic                   m_sus1;

    usb_rf_top dut0 (
        .wclk           (wclk),
        .rst            (rst),
        .adr            (adr),
        .re             (re),
        .we             (we),
        .din            (din),
        .dout           (dout),
        .line_status    (line_status),
        .errs           (errs),
        .frm_nat        (frm_nat),
        .utmi_vend_stat (utmi_vend_stat),
        .utmi_vend_ctrl (utmi_vend_ctrl),
        .utmi_vend_wr   (utmi_vend_wr),
        .rf_resume_req  (rf_resume_req)
    );

    initial
    begin
        wclk = 1'b0;
        forever #CLK_HALF wclk = ~wclk;
    end

    task automatic abort_run(input string msg);
        err_cnt = err_cnt + 1;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // Expected read word for an index, map taken from the register list
    function automatic usb_rf_pkg::reg_data_t read_word(input usb_rf_pkg::reg_adr_t a);
        usb_rf_pkg::reg_data_t w;
        w = '0;
        case (a)
            7'd0: w[4:0] = line_status;
            7'd1: w[6:0] = m_funct;
            7'd2:
            begin
                w[8:0]   = m_inta;
                w[24:16] = m_intb;
            end
            7'd3: w[24:16] = m_src;
            7'd4: w = frm_nat;
            7'd5: w[7:0] = m_vstat_r;
            default: w = '0;
        endcase
        return w;
    endfunction

    // Events seen one edge after the strobe or level change
    always_comb
    begin
        m_ev               = '0;
        m_ev.usb_reset     = m_errs_r.usb_reset;
        m_ev.rx_err        = m_errs_r.rx_err;
        m_ev.nse_err       = m_errs_r.nse_err;
        m_ev.pid_cs_err    = m_errs_r.pid_cs_err;
        m_ev.crc5_err      = m_errs_r.crc5_err;
        m_ev.attach        = m_att0 & ~m_att1;
        m_ev.deattach      = ~m_att0 & m_att1;
        m_ev.suspend_start = m_sus0 & ~m_sus1;
        m_ev.suspend_end   = ~m_sus0 & m_sus1;
    end

    always @(posedge wclk)
    begin
        m_errs_r  <= errs;
        m_att0    <= line_status.usb_attached;
        m_att1    <= m_att0;
        m_sus0    <= line_status.suspend;
        m_sus1    <= m_sus0;
        m_vstat_r <= utmi_vend_stat;
        exp_dout  <= read_word(adr);
        if (!rst)
        begin
            m_funct    <= '0;
            m_inta     <= '0;
            m_intb     <= '0;
            m_src      <= '0;
            m_clr      <= 1'b0;
            m_vend_wr  <= 1'b0;
            m_resume   <= 1'b0;
            m_vctrl_ok <= 1'b0;
        end
        else
        begin
            if (we && adr == 7'd1)
                m_funct <= din[6:0];
            if (we && adr == 7'd2)
            begin
                m_inta <= din[8:0];
                m_intb <= din[24:16];
            end
            if (we && adr == 7'd5)
            begin
                m_vctrl    <= din[3:0];
                m_vctrl_ok <= 1'b1;
            end
            // Clear wins over any event of the same cycle
            m_src     <= m_clr ? '0 : usb_rf_pkg::int_src_t'(m_src | m_ev);
            m_clr     <= re && adr == 7'd3;
            m_vend_wr <= we && adr == 7'd5;
            m_resume  <= we && adr == 7'd0 && din[5];
        end
    end

    //////////////////////////////////////////////////
    // Checks

    dout_a: assert property (@(posedge wclk) disable iff (!chk_on) dout == exp_dout)
        else abort_run($sformatf("Mismatch at %0t: dout expected %h, got %h",
            $time, $sampled(exp_dout), $sampled(dout)));

    vend_wr_a: assert property (@(posedge wclk) disable iff (!chk_on)
        utmi_vend_wr == m_vend_wr)
        else abort_run($sformatf("Mismatch at %0t: utmi_vend_wr expected %b, got %b",
            $time, $sampled(m_vend_wr), $sampled(utmi_vend_wr)));

    vend_ctrl_a: assert property (@(posedge wclk) disable iff (!chk_on)
        !m_vctrl_ok || utmi_vend_ctrl == m_vctrl)
        else abort_run($sformatf("Mismatch at %0t: utmi_vend_ctrl expected %h, got %h",
            $time, $sampled(m_vctrl), $sampled(utmi_vend_ctrl)));

    resume_a: assert property (@(posedge wclk) disable iff (!chk_on)
        rf_resume_req == m_resume)
        else abort_run($sformatf("Mismatch at %0t: rf_resume_req expected %b, got %b",
            $time, $sampled(m_resume), $sampled(rf_resume_req)));

    //////////////////////////////////////////////////
    // Stimulus

    // Background PHY activity during mixed traffic
    task automatic drive_noise();
        logic [31:0] rnd;
        rnd = $urandom;
        errs = (rnd[31:30] == 2'b00) ? usb_rf_pkg::usb_err_t'(rnd[4:0]) : '0;
        if (rnd[29:27] == 3'd0)
            line_status = usb_rf_pkg::usb_line_status_t'(rnd[12:8]);
        utmi_vend_stat = rnd[23:16];
        frm_nat = $urandom;
    endtask

    // One bus cycle, followed by an idle edge
    task automatic bus_op(input usb_rf_pkg::reg_adr_t a, input logic r, input logic w,
                          input usb_rf_pkg::reg_data_t d);
        @(posedge wclk);
        #1;
        if (noise_on)
            drive_noise();
        adr = a;
        re  = r;
        we  = w;
        din = d;
        @(posedge wclk);
        #1;
        re   = 1'b0;
        we   = 1'b0;
        errs = '0;
    endtask

    task automatic write_reg(input usb_rf_pkg::reg_adr_t a, input usb_rf_pkg::reg_data_t d);
        bus_op(a, 1'b0, 1'b1, d);
    endtask

    task automatic read_reg(input usb_rf_pkg::reg_adr_t a);
        bus_op(a, 1'b1, 1'b0, '0);
    endtask

    task automatic write_vend(input usb_rf_pkg::reg_data_t d);
        int n;
        write_reg(7'd5, d);
        n = 0;
        while (!utmi_vend_wr && n < PULSE_MAX)
        begin
            @(posedge wclk);
            n = n + 1;
        end
        if (!utmi_vend_wr)
            abort_run("Vendor write strobe never rose after a write to index 5");
    endtask

    task automatic request_resume(input usb_rf_pkg::reg_data_t d);
        int n;
        write_reg(7'd0, d);
        n = 0;
        while (d[5] && !rf_resume_req && n < PULSE_MAX)
        begin
            @(posedge wclk);
            n = n + 1;
        end
        if (d[5] && !rf_resume_req)
            abort_run("Resume request never rose after a write with bit 5 set");
    endtask

    // One cycle of random error strobes, then drain the source register
    task automatic pulse_errors();
        logic [31:0] rnd;
        rnd = $urandom_range(31, 1);
        @(posedge wclk);
        #1;
        errs = usb_rf_pkg::usb_err_t'(rnd[4:0]);
        @(posedge wclk);
        #1;
        errs = '0;
        read_reg(7'd3);
        read_reg(7'd3);
    endtask

    initial
    begin
        logic [31:0] rnd;
        void'($urandom(SEED));
        rst            = 1'b0;
        adr            = '0;
        re             = 1'b0;
        we             = 1'b0;
        din            = '0;
        line_status    = '0;
        errs           = '0;
        frm_nat        = '0;
        utmi_vend_stat = '0;
        chk_on         = 1'b0;
        noise_on       = 1'b0;
        err_cnt        = 0;
        repeat (4) @(posedge wclk);
        #1;
        rst = 1'b1;
        @(posedge wclk);
        #1;
        chk_on = 1'b1;

        // Reset values
        read_reg(7'd1);
        read_reg(7'd2);
        read_reg(7'd3);

        // Writable registers
        for (int i = 0; i < 20; i++)
        begin
            write_reg(7'd1, $urandom);
            read_reg(7'd1);
            write_reg(7'd2, $urandom);
            read_reg(7'd2);
        end

        // Live and registered status, unmapped addresses
        for (int i = 0; i < 20; i++)
        begin
            rnd = $urandom;
            line_status    = usb_rf_pkg::usb_line_status_t'(rnd[4:0]);
            utmi_vend_stat = rnd[15:8];
            frm_nat        = $urandom;
            read_reg(7'd0);
            read_reg(7'd4);
            read_reg(7'd5);
            rnd = $urandom_range(127, 6);
            read_reg(rnd[6:0]);
        end

        // Interrupt source events
        for (int i = 0; i < 16; i++)
        begin
            pulse_errors();
            line_status.usb_attached = ~line_status.usb_attached;
            read_reg(7'd3);
            read_reg(7'd3);
            line_status.suspend = ~line_status.suspend;
            read_reg(7'd3);
            read_reg(7'd3);
        end

        // Vendor control and resume
        for (int i = 0; i < 12; i++)
        begin
            write_vend($urandom);
            request_resume(32'h0000_0020 | $urandom);
            request_resume(32'hffff_ffdf & $urandom);
        end

        // Mixed traffic with PHY activity
        noise_on = 1'b1;
        for (int i = 0; i < 300; i++)
        begin
            rnd = $urandom;
            case (rnd[2:0])
                3'd0: read_reg(7'd3);
                3'd1: write_reg(7'd0, $urandom);
                3'd2: write_reg(7'd5, $urandom);
                3'd3: write_reg(7'd1, $urandom);
                3'd4: write_reg(7'd2, $urandom);
                3'd5: read_reg({4'd0, rnd[10:8]});
                3'd6: read_reg(7'd3);
                default: read_reg(rnd[14:8]);
            endcase
        end
        noise_on = 1'b0;
        repeat (4) @(posedge wclk);

        if (err_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* verilog.f */
verilog/usb_rf_pkg.sv
verilog/usb_line_events.sv
verilog/usb_int_source.sv
verilog/usb_func_regs.sv
verilog/usb_rf_top.sv
test/usb_rf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module usb_rf_tb \
    --Mdir obj_dir \
    -o usb_rf_sim \
    -f verilog.f

./obj_dir/usb_rf_sim 2>&1 | tee "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if ! grep -q "Done: no errors" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation PASSED"
